/* Makefile */
TOP := cgmii_gen_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

/* common/cgmii_bus_pkg.sv */
`default_nettype none
`include "cgmii_consts.svh"

package cgmii_bus_pkg;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [2:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	typedef enum logic [2:0] {
		REG_CTRL     = `CGMII_ADDR_CTRL,
		REG_IDLE_LEN = `CGMII_ADDR_IDLE_LEN,
		REG_DATA_LEN = `CGMII_ADDR_DATA_LEN,
		REG_FORCE    = `CGMII_ADDR_FORCE,    // Write only
		REG_STATUS   = `CGMII_ADDR_STATUS    // Read only
	} reg_addr_e;

endpackage

`default_nettype wire

/* common/cgmii_consts.svh */
`ifndef CGMII_CONSTS_SVH
`define CGMII_CONSTS_SVH

// Counter widths
`define CGMII_IDLE_NBIT       5
`define CGMII_DATA_NBIT       8
`define CGMII_FRAME_CNT_NBIT  16

// CGMII control characters
`define CGMII_CH_IDLE   8'h07
`define CGMII_CH_START  8'hFB
`define CGMII_CH_TERM   8'hFD
`define CGMII_CH_ERROR  8'hFE

`define CGMII_PREAMBLE  8'h55
`define CGMII_SFD       8'hD5   // Start of frame delimiter

// Register word addresses
`define CGMII_ADDR_CTRL      3'd0
`define CGMII_ADDR_IDLE_LEN  3'd1
`define CGMII_ADDR_DATA_LEN  3'd2
`define CGMII_ADDR_FORCE     3'd3
`define CGMII_ADDR_STATUS    3'd4

`endif

/* common/cgmii_line_pkg.sv */
`default_nettype none
`include "cgmii_consts.svh"

package cgmii_line_pkg;

	// One-hot sequencer states
	typedef enum logic [5:0] {
		INIT = 6'b000001,
		TX_C = 6'b000010,
		TX_S = 6'b000100,
		TX_D = 6'b001000,
		TX_T = 6'b010000,
		TX_E = 6'b100000
	} seq_state_e;

	typedef enum logic [2:0] {
		FORCE_NONE         = 3'd0,
		FORCE_ERROR        = 3'd1,
		FORCE_CONTROL      = 3'd2,
		FORCE_DATA         = 3'd3,
		FORCE_DATA_RESTART = 3'd4,   // Data counter back to 1
		FORCE_TERMINATE    = 3'd5
	} force_op_e;

	typedef struct packed {
		logic                        enable;
		logic [`CGMII_IDLE_NBIT-1:0] idle_len;
		logic [`CGMII_DATA_NBIT-1:0] data_len;
	} gen_cfg_t;

	// Lane k is data[8*k +: 8], ctrl[k] set for a control byte
	typedef struct packed {
		logic [63:0] data;
		logic [7:0]  ctrl;
	} cgmii_word_t;

endpackage

`default_nettype wire

/* compile.f */
+incdir+common
common/cgmii_line_pkg.sv
common/cgmii_bus_pkg.sv
source/cgmii_regs.sv
frame_gen/cgmii_frame_fsm.sv
frame_gen/cgmii_lane_encoder.sv
source/cgmii_gen_top.sv
verif/tb_clock_gen.sv
verif/cgmii_gen_tb.sv

/* frame_gen/cgmii_frame_fsm.sv */
`default_nettype none
`include "cgmii_consts.svh"

module cgmii_frame_fsm (
	input  wire                            i_clock,
	input  wire                            i_reset,
	input  wire cgmii_line_pkg::gen_cfg_t  i_cfg,
	input  wire cgmii_line_pkg::force_op_e i_force,
	output cgmii_line_pkg::seq_state_e     o_state,
	output logic                           o_frame_done
);

	cgmii_line_pkg::seq_state_e    state_next;
	logic [`CGMII_IDLE_NBIT-1:0]   idle_cnt;
	logic [`CGMII_IDLE_NBIT-1:0]   idle_cnt_next;
	logic [`CGMII_DATA_NBIT-1:0]   data_cnt;
	logic [`CGMII_DATA_NBIT-1:0]   data_cnt_next;
	logic [`CGMII_IDLE_NBIT-1:0]   n_idle;
	logic [`CGMII_IDLE_NBIT-1:0]   n_idle_next;
	logic [`CGMII_DATA_NBIT-1:0]   n_data;
	logic [`CGMII_DATA_NBIT-1:0]   n_data_next;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_state      <= cgmii_line_pkg::INIT;
			idle_cnt     <= '0;
			data_cnt     <= '0;
			n_idle       <= i_cfg.idle_len;
			n_data       <= i_cfg.data_len;
			o_frame_done <= 1'b0;
		end else begin
			o_frame_done <= i_cfg.enable && (o_state == cgmii_line_pkg::TX_T);
			if (i_cfg.enable) begin   // Frozen while disabled
				o_state  <= state_next;
				idle_cnt <= idle_cnt_next;
				data_cnt <= data_cnt_next;
				n_idle   <= n_idle_next;
				n_data   <= n_data_next;
			end
		end
	end

	always_comb begin
		state_next    = o_state;
		idle_cnt_next = idle_cnt;
		data_cnt_next = data_cnt;
		n_idle_next   = n_idle;
		n_data_next   = n_data;

		case (i_force)
			cgmii_line_pkg::FORCE_ERROR: begin
				state_next    = cgmii_line_pkg::TX_E;
				idle_cnt_next = '0;
				data_cnt_next = '0;
			end
			cgmii_line_pkg::FORCE_CONTROL: begin
				state_next = cgmii_line_pkg::TX_C;
			end
			cgmii_line_pkg::FORCE_DATA: begin
				state_next = cgmii_line_pkg::TX_D;
			end
			cgmii_line_pkg::FORCE_DATA_RESTART: begin
				data_cnt_next = {{(`CGMII_DATA_NBIT-1){1'b0}}, 1'b1};
			end
			cgmii_line_pkg::FORCE_TERMINATE: begin
				state_next = cgmii_line_pkg::TX_T;
			end
			default: begin
				// Normal sequencing
				case (o_state)
					cgmii_line_pkg::INIT: begin
						state_next = cgmii_line_pkg::TX_C;
					end
					cgmii_line_pkg::TX_C: begin
						if (idle_cnt < n_idle) begin
							idle_cnt_next = idle_cnt + 1'b1;
						end else begin
							idle_cnt_next = '0;
							state_next    = cgmii_line_pkg::TX_S;
						end
					end
					cgmii_line_pkg::TX_S: begin
						state_next = cgmii_line_pkg::TX_D;
					end
					cgmii_line_pkg::TX_D: begin
						if (data_cnt < n_data) begin
							data_cnt_next = data_cnt + 1'b1;
						end else begin
							data_cnt_next = '0;
							state_next    = cgmii_line_pkg::TX_T;
						end
					end
					cgmii_line_pkg::TX_T: begin
						n_idle_next   = i_cfg.idle_len;   // New lengths from next gap
						n_data_next   = i_cfg.data_len;
						idle_cnt_next = '0;
						data_cnt_next = '0;   // Frame may have been cut short
						state_next    = cgmii_line_pkg::TX_C;
					end
					cgmii_line_pkg::TX_E: begin
						state_next = cgmii_line_pkg::TX_C;
					end
					default: begin
						state_next = cgmii_line_pkg::TX_E;   // Illegal encoding
					end
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

/* frame_gen/cgmii_lane_encoder.sv */
`default_nettype none
`include "cgmii_consts.svh"

module cgmii_lane_encoder (
	input  wire                             i_clock,
	input  wire                             i_reset,
	input  wire                             i_enable,
	input  wire cgmii_line_pkg::seq_state_e i_state,
	output cgmii_line_pkg::cgmii_word_t     o_word,
	output logic                            o_valid
);

	cgmii_line_pkg::cgmii_word_t  word_next;
	logic [7:0]                   payload_cnt;

	always_comb begin
		word_next.data = {8{`CGMII_CH_ERROR}};
		word_next.ctrl = 8'hFF;

		case (i_state)
			cgmii_line_pkg::INIT,
			cgmii_line_pkg::TX_C: begin
				word_next.data = {8{`CGMII_CH_IDLE}};
				word_next.ctrl = 8'hFF;
			end
			cgmii_line_pkg::TX_S: begin
				// Start in lane 0, SFD in lane 7
				word_next.data = {`CGMII_SFD, {6{`CGMII_PREAMBLE}}, `CGMII_CH_START};
				word_next.ctrl = 8'h01;
			end
			cgmii_line_pkg::TX_D: begin
				word_next.ctrl = 8'h00;
				for (int k = 0; k < 8; k++) begin
					word_next.data[8*k +: 8] = payload_cnt + 8'(k);
				end
			end
			cgmii_line_pkg::TX_T: begin
				word_next.data = {{7{`CGMII_CH_IDLE}}, `CGMII_CH_TERM};
				word_next.ctrl = 8'hFF;
			end
			cgmii_line_pkg::TX_E: begin
				word_next.data = {8{`CGMII_CH_ERROR}};
				word_next.ctrl = 8'hFF;
			end
			default: begin
				word_next.data = {8{`CGMII_CH_ERROR}};
				word_next.ctrl = 8'hFF;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid     <= 1'b0;
			payload_cnt <= '0;
		end else begin
			o_valid <= i_enable;
			if (i_enable && (i_state == cgmii_line_pkg::TX_D)) begin
				payload_cnt <= payload_cnt + 8'd8;   // One byte per lane
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_enable) begin
			o_word <= word_next;
		end
	end

endmodule

`default_nettype wire

/* source/cgmii_gen_top.sv */
`default_nettype none

module cgmii_gen_top (
	input  wire                              i_clock,
	input  wire                              i_reset,
	input  wire cgmii_bus_pkg::wb_req_t      i_wb,
	output wire cgmii_bus_pkg::wb_rsp_t      o_wb,
	output wire cgmii_line_pkg::cgmii_word_t o_word,
	output wire                              o_valid
);

	wire cgmii_line_pkg::gen_cfg_t    cfg;
	wire cgmii_line_pkg::force_op_e   force_op;
	wire cgmii_line_pkg::seq_state_e  state;
	wire                              frame_done;

	// Register bus, configuration and frame count
	cgmii_regs u_regs (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_wb         (i_wb),
		.o_wb         (o_wb),
		.i_state      (state),
		.i_frame_done (frame_done),
		.o_cfg        (cfg),
		.o_force      (force_op)
	);

	cgmii_frame_fsm u_fsm (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_cfg        (cfg),
		.i_force      (force_op),
		.o_state      (state),
		.o_frame_done (frame_done)
	);

	// One line word per enabled cycle
	cgmii_lane_encoder u_encoder (
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_enable (cfg.enable),
		.i_state  (state),
		.o_word   (o_word),
		.o_valid  (o_valid)
	);

endmodule

`default_nettype wire

/* source/cgmii_regs.sv */
`default_nettype none
`include "cgmii_consts.svh"

module cgmii_regs (
	input  wire                             i_clock,
	input  wire                             i_reset,
	input  wire cgmii_bus_pkg::wb_req_t     i_wb,
	output wire cgmii_bus_pkg::wb_rsp_t     o_wb,
	input  wire cgmii_line_pkg::seq_state_e i_state,
	input  wire                             i_frame_done,
	output cgmii_line_pkg::gen_cfg_t        o_cfg,
	output cgmii_line_pkg::force_op_e       o_force
);

	logic                              req;
	logic                              take;
	logic                              served;
	logic                              ack;
	logic [31:0]                       rdata;
	logic [31:0]                       rdata_next;
	logic [`CGMII_FRAME_CNT_NBIT-1:0]  frame_cnt;

	assign req  = i_wb.cyc & i_wb.stb;
	assign take = req & ~served;    // First cycle of a request only

	assign o_wb.ack = ack;
	assign o_wb.dat = rdata;

	// Served stays set until the master drops the request
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			ack    <= 1'b0;
			served <= 1'b0;
		end else begin
			ack    <= take;
			served <= req & (served | take);
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_cfg   <= '0;
			o_force <= cgmii_line_pkg::FORCE_NONE;
		end else begin
			o_force <= cgmii_line_pkg::FORCE_NONE;   // One-shot
			if (take && i_wb.we) begin
				case (cgmii_bus_pkg::reg_addr_e'(i_wb.adr))
					cgmii_bus_pkg::REG_CTRL: begin
						o_cfg.enable <= i_wb.dat[0];
					end
					cgmii_bus_pkg::REG_IDLE_LEN: begin
						o_cfg.idle_len <= i_wb.dat[`CGMII_IDLE_NBIT-1:0];
					end
					cgmii_bus_pkg::REG_DATA_LEN: begin
						o_cfg.data_len <= i_wb.dat[`CGMII_DATA_NBIT-1:0];
					end
					cgmii_bus_pkg::REG_FORCE: begin
						o_force <= cgmii_line_pkg::force_op_e'(i_wb.dat[2:0]);
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Completed frames
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			frame_cnt <= '0;
		end else if (i_frame_done) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	always_comb begin
		rdata_next = '0;
		case (cgmii_bus_pkg::reg_addr_e'(i_wb.adr))
			cgmii_bus_pkg::REG_CTRL: begin
				rdata_next[0] = o_cfg.enable;
			end
			cgmii_bus_pkg::REG_IDLE_LEN: begin
				rdata_next[`CGMII_IDLE_NBIT-1:0] = o_cfg.idle_len;
			end
			cgmii_bus_pkg::REG_DATA_LEN: begin
				rdata_next[`CGMII_DATA_NBIT-1:0] = o_cfg.data_len;
			end
			cgmii_bus_pkg::REG_STATUS: begin
				rdata_next[`CGMII_FRAME_CNT_NBIT-1:0] = frame_cnt;
				rdata_next[21:16]                     = i_state;   // Upper half
			end
			default: begin
				rdata_next = '0;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (take) begin
			rdata <= rdata_next;
		end
	end

endmodule

`default_nettype wire

/* verif/cgmii_gen_tb.sv */
`default_nettype none
`include "cgmii_consts.svh"

module cgmii_gen_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DRIVE_DELAY   = 2;
	localparam int ACK_TIMEOUT   = 16;
	localparam int FRAME_TIMEOUT = 400;
	localparam int ROOM          = 12;   // Data words still ahead when the bus is touched
	localparam int FORCE_LATENCY = 5;    // Words from the check point to the forced word

	// Model phases double as word kinds
	localparam int P_INIT  = 0;
	localparam int P_GAP   = 1;
	localparam int P_START = 2;
	localparam int P_DATA  = 3;
	localparam int P_TERM  = 4;
	localparam int P_ERROR = 5;

	wire                         clock;
	wire                         reset;
	cgmii_bus_pkg::wb_req_t      wb_req;
	cgmii_bus_pkg::wb_rsp_t      wb_rsp;
	cgmii_line_pkg::cgmii_word_t line_word;
	logic                        line_valid;

	integer     seed;
	logic       bus_started  = 1'b0;
	logic       enable_seen  = 1'b0;
	logic       err_pending  = 1'b0;
	logic       term_pending = 1'b0;
	int         phase        = P_INIT;
	int         left         = 0;
	int         n_idle       = 0;   // Lengths latched at reset are zero
	int         n_data       = 0;
	int         cfg_idle     = 0;
	int         cfg_data     = 0;
	int         term_count   = 0;
	int         word_count   = 0;
	int         forced_at    = 0;
	logic [7:0] payload      = 8'h00;

	tb_clock_gen clock_gen0 (
		.o_clock (clock),
		.o_reset (reset)
	);

	cgmii_gen_top dut0 (
		.i_clock (clock),
		.i_reset (reset),
		.i_wb    (wb_req),
		.o_wb    (wb_rsp),
		.o_word  (line_word),
		.o_valid (line_valid)
	);

	task automatic stop_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic abort_run(input string why);
		$display("%0t ns: %s", $time, why);
		stop_run();
	endtask

	task automatic value_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		stop_run();
	endtask

	function automatic cgmii_line_pkg::cgmii_word_t expected_word(input int kind,
		input logic [7:0] base);
		cgmii_line_pkg::cgmii_word_t w;
		w.ctrl = (kind == P_DATA) ? 8'h00 : ((kind == P_START) ? 8'h01 : 8'hFF);
		for (int k = 0; k < 8; k++) begin
			case (kind)
				P_INIT, P_GAP: w.data[8*k +: 8] = `CGMII_CH_IDLE;
				P_START: w.data[8*k +: 8] = (k == 0) ? `CGMII_CH_START :
					((k == 7) ? `CGMII_SFD : `CGMII_PREAMBLE);
				P_DATA: w.data[8*k +: 8] = base + 8'(k);   // Lane k holds count+k
				P_TERM: w.data[8*k +: 8] = (k == 0) ? `CGMII_CH_TERM : `CGMII_CH_IDLE;
				default: w.data[8*k +: 8] = `CGMII_CH_ERROR;
			endcase
		end
		return w;
	endfunction

	// Sequencer state that produces the next word of a phase
	function automatic logic [5:0] state_of_phase(input int p);
		case (p)
			P_GAP:   return cgmii_line_pkg::TX_C;
			P_START: return cgmii_line_pkg::TX_S;
			P_DATA:  return cgmii_line_pkg::TX_D;
			P_TERM:  return cgmii_line_pkg::TX_T;
			P_ERROR: return cgmii_line_pkg::TX_E;
			default: return cgmii_line_pkg::INIT;
		endcase
	endfunction

	// New lengths only take hold after a terminate word
	function automatic void close_frame();
		term_count++;
		n_idle = cfg_idle;
		n_data = cfg_data;
		phase  = P_GAP;
		left   = n_idle + 1;
	endfunction

	function automatic void advance_model();
		case (phase)
			P_INIT: begin
				phase = P_GAP;
				left  = n_idle + 1;
			end
			P_GAP: begin
				left--;
				if (left == 0) phase = P_START;
			end
			P_START: begin
				phase = P_DATA;
				left  = n_data + 1;
			end
			P_DATA: begin
				payload = payload + 8'd8;
				left--;
				if (left == 0) phase = P_TERM;
			end
			default: close_frame();
		endcase
	endfunction

	// One model step per valid word at the falling edge
	always @(negedge clock) begin
		cgmii_line_pkg::cgmii_word_t exp;
		if (reset === 1'b0) begin
			if (!bus_started) begin
				assert (wb_rsp.ack === 1'b0) else abort_run("ack raised before any request");
			end
			if (!enable_seen) begin
				assert (line_valid === 1'b0) else abort_run("valid raised while never enabled");
			end
			if (line_valid) begin
				word_count++;
				if (err_pending && line_word === expected_word(P_ERROR, 8'h00)) begin
					err_pending = 1'b0;
					forced_at   = word_count;
					phase       = P_GAP;
					left        = n_idle + 1;
				end else if (term_pending && phase == P_DATA &&
					line_word === expected_word(P_TERM, 8'h00)) begin
					term_pending = 1'b0;
					forced_at    = word_count;
					close_frame();
				end else begin
					exp = expected_word(phase, payload);
					assert (line_word.ctrl === exp.ctrl)
						else value_mismatch("o_word.ctrl", line_word.ctrl, exp.ctrl);
					assert (line_word.data === exp.data)
						else value_mismatch("o_word.data", line_word.data, exp.data);
					advance_model();
				end
			end
		end
	end

	task automatic wait_ack();
		int n;
		n = 0;
		@(negedge clock);
		while (wb_rsp.ack !== 1'b1) begin
			n++;
			if (n > ACK_TIMEOUT) abort_run("timeout waiting for Wishbone ack");
			@(negedge clock);
		end
	endtask

	// Ack must be gone one cycle after the request drops
	task automatic release_bus();
		@(posedge clock);
		#DRIVE_DELAY;
		wb_req = '0;
		@(negedge clock);
		assert (wb_rsp.ack === 1'b0) else abort_run("ack held for more than one cycle");
		@(posedge clock);
	endtask

	task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		@(posedge clock);
		#DRIVE_DELAY;
		bus_started = 1'b1;
		wb_req.cyc  = 1'b1;
		wb_req.stb  = 1'b1;
		wb_req.we   = we;
		wb_req.adr  = adr;
		wb_req.dat  = wdat;
		wait_ack();
		rdat = wb_rsp.dat;
		if (we && adr == `CGMII_ADDR_IDLE_LEN) cfg_idle = int'(wdat[`CGMII_IDLE_NBIT-1:0]);
		if (we && adr == `CGMII_ADDR_DATA_LEN) cfg_data = int'(wdat[`CGMII_DATA_NBIT-1:0]);
		release_bus();
	endtask

	task automatic bus_write(input logic [2:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_access(1'b1, adr, dat, unused);
	endtask

	task automatic read_expect(input logic [2:0] adr, input logic [31:0] exp,
		input string name);
		logic [31:0] got;
		bus_access(1'b0, adr, 32'd0, got);
		assert (got === exp) else value_mismatch(name, got, exp);
	endtask

	task automatic wait_data_room(output int mark);
		int n;
		n = 0;
		@(posedge clock);
		while (!(phase == P_DATA && left >= ROOM)) begin
			n++;
			if (n > FRAME_TIMEOUT) abort_run("timeout waiting for the middle of a frame");
			@(posedge clock);
		end
		mark = word_count;
	endtask

	task automatic wait_frames(input int frames);
		int target;
		int n;
		target = term_count + frames;
		n = 0;
		while (term_count < target) begin
			n++;
			if (n > FRAME_TIMEOUT * frames) abort_run("timeout waiting for terminate words");
			@(posedge clock);
		end
	endtask

	task automatic wait_forced(input int mark);
		int n;
		n = 0;
		while (err_pending || term_pending) begin
			n++;
			if (n > ACK_TIMEOUT) abort_run("forced word never appeared");
			@(posedge clock);
		end
		assert (forced_at - mark == FORCE_LATENCY)
			else abort_run("forced word did not follow the force command directly");
	endtask

	initial begin
		logic [31:0] rnd;
		logic [31:0] rd;
		int          mark;
		int          count_before;
		int          n;

		seed   = 32'h207f;
		wb_req = '0;
		n      = 0;
		while (reset !== 1'b0) begin
			n++;
			if (n > 20) abort_run("reset never released");
			@(posedge clock);
		end
		repeat (4) @(posedge clock);

		// Register readback while disabled
		bus_write(`CGMII_ADDR_IDLE_LEN, 32'd3);
		bus_write(`CGMII_ADDR_DATA_LEN, 32'd12);
		read_expect(`CGMII_ADDR_IDLE_LEN, 32'd3, "o_wb.dat at IDLE_LEN");
		read_expect(`CGMII_ADDR_DATA_LEN, 32'd12, "o_wb.dat at DATA_LEN");
		read_expect(`CGMII_ADDR_CTRL, 32'd0, "o_wb.dat at CTRL");
		for (int a = 5; a < 8; a++) begin
			read_expect(3'(a), 32'd0, "o_wb.dat at unused address");
		end
		bus_write(`CGMII_ADDR_FORCE, 32'(cgmii_line_pkg::FORCE_ERROR));   // Lost, not enabled
		enable_seen = 1'b1;
		bus_write(`CGMII_ADDR_CTRL, 32'd1);
		read_expect(`CGMII_ADDR_CTRL, 32'd1, "o_wb.dat at CTRL");

		// Random lengths written in the middle of a frame
		for (int i = 0; i < 5; i++) begin
			wait_data_room(mark);
			rnd = $random(seed);
			bus_write(`CGMII_ADDR_IDLE_LEN, 32'd1 + {28'd0, rnd[3:0]});
			bus_write(`CGMII_ADDR_DATA_LEN, 32'd12 + {28'd0, rnd[7:4]});
			wait_frames(2);
		end

		// Pause and resume
		wait_data_room(mark);
		bus_write(`CGMII_ADDR_CTRL, 32'd0);
		count_before = word_count;
		repeat (6) @(posedge clock);
		#DRIVE_DELAY;
		assert (line_valid === 1'b0) else value_mismatch("o_valid", line_valid, 1'b0);
		assert (word_count == count_before) else abort_run("words appeared while disabled");
		bus_write(`CGMII_ADDR_CTRL, 32'd1);
		wait_frames(2);

		wait_data_room(mark);
		err_pending = 1'b1;
		bus_write(`CGMII_ADDR_FORCE, 32'(cgmii_line_pkg::FORCE_ERROR));
		wait_forced(mark);
		wait_frames(1);
		wait_data_room(mark);
		term_pending = 1'b1;
		bus_write(`CGMII_ADDR_FORCE, 32'(cgmii_line_pkg::FORCE_TERMINATE));
		wait_forced(mark);
		wait_frames(1);

		// Frame count against the terminate words seen
		bus_write(`CGMII_ADDR_CTRL, 32'd0);
		repeat (4) @(posedge clock);
		bus_access(1'b0, `CGMII_ADDR_STATUS, 32'd0, rd);
		assert (rd[15:0] === 16'(term_count))
			else value_mismatch("o_wb.dat[15:0]", rd[15:0], 16'(term_count));
		assert (rd[21:16] === state_of_phase(phase))
			else value_mismatch("o_wb.dat[21:16]", rd[21:16], state_of_phase(phase));
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
	output logic o_clock,
	output logic o_reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		o_clock = 1'b0;
		forever #10 o_clock = ~o_clock;   // 20 ns period
	end

	// Released just after the fifth rising edge
	initial begin
		o_reset = 1'b1;
		repeat (5) @(posedge o_clock);
		#2 o_reset = 1'b0;
	end

endmodule

`default_nettype wire
